//--- rtl/eu_pkg.sv
package eu_pkg;

    // data path widths
    localparam int BYTE_WIDTH = 8;
    localparam int WORD_WIDTH = 16;
    localparam int ADDR_WIDTH = 20;

    typedef logic [BYTE_WIDTH-1:0] byte_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] phys_addr_t;
    typedef logic [2:0]            reg_id_t;

    // word register numbers used by the address table
    localparam reg_id_t REG_BX = 3'd3;
    localparam reg_id_t REG_BP = 3'd5;
    localparam reg_id_t REG_SI = 3'd6;
    localparam reg_id_t REG_DI = 3'd7;

    // mod value that selects a register operand
    localparam logic [1:0] MOD_REGISTER = 2'd3;
    // rm value that means direct address when mod is 00
    localparam logic [2:0] RM_DIRECT = 3'b110;

    // segment is paragraph aligned
    localparam int SEGMENT_SHIFT = 4;

    typedef enum logic [1:0]
    {
        BUS_IDLE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_command_t;

    typedef enum logic [2:0]
    {
        MOV_NONE         = 3'd0,
        MOV_REG_FROM_RM  = 3'd1,
        MOV_RM_FROM_REG  = 3'd2,
        MOV_REG_FROM_IMM = 3'd3,
        MOV_RM_FROM_IMM  = 3'd4
    } mov_kind_t;

    typedef enum logic [2:0]
    {
        FETCH_OPCODE    = 3'd0,
        FETCH_MODRM     = 3'd1,
        FETCH_DISP_LOW  = 3'd2,
        FETCH_DISP_HIGH = 3'd3,
        FETCH_IMM_LOW   = 3'd4,
        FETCH_IMM_HIGH  = 3'd5,
        FETCH_EXECUTE   = 3'd6
    } fetch_state_t;

    typedef enum logic [1:0]
    {
        EXEC_START  = 2'd0,
        EXEC_BUS    = 2'd1,
        EXEC_FINISH = 2'd2
    } exec_state_t;

endpackage

//--- rtl/mov_decode.sv
`timescale 1ns/1ps

module mov_decode
    import eu_pkg::*;
(
    input  byte_t     opcode,
    input  byte_t     modrm,
    output logic      need_modrm,
    output logic      need_disp,
    output logic      disp_word,
    output logic      need_imm,
    output logic      imm_word,
    output logic      word_op,
    output mov_kind_t kind,
    output reg_id_t   reg_field,
    output reg_id_t   rm_field,
    output logic      rm_is_memory
);

    logic [1:0] mod_field;
    logic       direct;

    assign mod_field = modrm[7:6];
    // mod 00 with rm 110 is a bare 16-bit address
    assign direct = (mod_field == 2'b00) && (modrm[2:0] == RM_DIRECT);

    always_comb
    begin
        // unknown opcodes are a single byte with no effect
        kind       = MOV_NONE;
        need_modrm = 1'b0;
        need_imm   = 1'b0;
        imm_word   = 1'b0;
        word_op    = opcode[0];
        reg_field  = modrm[5:3];

        if (opcode[7:1] == 7'b1000101)
        begin
            // 8A/8B reg <- r/m
            kind       = MOV_REG_FROM_RM;
            need_modrm = 1'b1;
        end
        else if (opcode[7:1] == 7'b1000100)
        begin
            // 88/89 r/m <- reg
            kind       = MOV_RM_FROM_REG;
            need_modrm = 1'b1;
        end
        else if (opcode[7:4] == 4'hb)
        begin
            // B0..BF carry the width in bit 3 and the register in the low bits
            kind      = MOV_REG_FROM_IMM;
            need_imm  = 1'b1;
            imm_word  = opcode[3];
            word_op   = opcode[3];
            reg_field = opcode[2:0];
        end
        else if (opcode[7:1] == 7'b1100011)
        begin
            // C6/C7 r/m <- imm
            kind       = MOV_RM_FROM_IMM;
            need_modrm = 1'b1;
            need_imm   = 1'b1;
            imm_word   = opcode[0];
        end
    end

    assign rm_field     = modrm[2:0];
    assign rm_is_memory = (mod_field != MOD_REGISTER);

    // displacement only follows a modrm byte
    assign need_disp = need_modrm && rm_is_memory && ((mod_field != 2'b00) || direct);
    assign disp_word = (mod_field == 2'b10) || direct;

endmodule

//--- rtl/instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch
    import eu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  byte_t prefetch_data,
    input  logic  queue_empty,
    input  logic  need_modrm,
    input  logic  need_disp,
    input  logic  disp_word,
    input  logic  need_imm,
    input  logic  imm_word,
    input  logic  instruction_done,
    output logic  queue_pop,
    output byte_t opcode,
    output byte_t modrm,
    output word_t disp,
    output word_t imm,
    output logic  operands_valid
);

    fetch_state_t state;
    fetch_state_t next_state;
    byte_t        opcode_q;
    byte_t        modrm_q;

    // the byte being taken is visible to the decoder in the same cycle,
    // so the next field can be chosen without an extra cycle
    assign opcode = (state == FETCH_OPCODE) ? prefetch_data : opcode_q;
    assign modrm  = (state == FETCH_MODRM) ? prefetch_data : modrm_q;

    // no pops while an instruction executes
    assign queue_pop      = (state != FETCH_EXECUTE) && !queue_empty;
    assign operands_valid = (state == FETCH_EXECUTE);

    always_comb
    begin
        case (state)
            FETCH_OPCODE:
                next_state = need_modrm ? FETCH_MODRM :
                             need_imm   ? FETCH_IMM_LOW : FETCH_EXECUTE;
            FETCH_MODRM:
                next_state = need_disp ? FETCH_DISP_LOW :
                             need_imm  ? FETCH_IMM_LOW : FETCH_EXECUTE;
            FETCH_DISP_LOW:
                next_state = disp_word ? FETCH_DISP_HIGH :
                             need_imm  ? FETCH_IMM_LOW : FETCH_EXECUTE;
            FETCH_DISP_HIGH:
                next_state = need_imm ? FETCH_IMM_LOW : FETCH_EXECUTE;
            FETCH_IMM_LOW:
                next_state = imm_word ? FETCH_IMM_HIGH : FETCH_EXECUTE;
            FETCH_IMM_HIGH:
                next_state = FETCH_EXECUTE;
            default:
                // execute waits for the done pulse
                next_state = instruction_done ? FETCH_OPCODE : FETCH_EXECUTE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= FETCH_OPCODE;
        else if (queue_pop || (state == FETCH_EXECUTE))
            state <= next_state;
    end

    // low bytes are extended so 8-bit forms need no high fetch
    always_ff @(posedge clk)
    begin
        if (queue_pop)
        begin
            case (state)
                FETCH_OPCODE:    opcode_q   <= prefetch_data;
                FETCH_MODRM:     modrm_q    <= prefetch_data;
                FETCH_DISP_LOW:  disp       <= {{8{prefetch_data[7]}}, prefetch_data};
                FETCH_DISP_HIGH: disp[15:8] <= prefetch_data;
                FETCH_IMM_LOW:   imm        <= {8'h00, prefetch_data};
                FETCH_IMM_HIGH:  imm[15:8]  <= prefetch_data;
                default:         ;
            endcase
        end
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file
    import eu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  reg_id_t read_id,
    input  logic    read_word,
    input  reg_id_t addr_base_id,
    input  reg_id_t addr_index_id,
    input  reg_id_t write_id,
    input  logic    write_word,
    input  logic    write_enable,
    input  word_t   write_data,
    output word_t   read_data,
    output word_t   base_data,
    output word_t   index_data
);

    // AW CW DW BW SP BP IX IY
    word_t registers [0:7];

    word_t read_half_src;

    // byte ids 0-3 are low halves of AW..BW, 4-7 the high halves
    assign read_half_src = registers[{1'b0, read_id[1:0]}];

    always_comb
    begin
        if (read_word)
            read_data = registers[read_id];
        else if (read_id[2])
            read_data = {8'h00, read_half_src[15:8]};
        else
            read_data = {8'h00, read_half_src[7:0]};
    end

    // address port always reads whole words
    assign base_data  = registers[addr_base_id];
    assign index_data = registers[addr_index_id];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                registers[i] <= '0;
        end
        else if (write_enable)
        begin
            if (write_word)
                registers[write_id] <= write_data;
            else if (write_id[2])
                registers[{1'b0, write_id[1:0]}][15:8] <= write_data[7:0];
            else
                registers[{1'b0, write_id[1:0]}][7:0] <= write_data[7:0];
        end
    end

endmodule

//--- rtl/effective_address.sv
`timescale 1ns/1ps

module effective_address
    import eu_pkg::*;
(
    input  byte_t      modrm,
    input  word_t      disp,
    input  word_t      base_data,
    input  word_t      index_data,
    input  word_t      ds,
    input  word_t      ss,
    output reg_id_t    base_id,
    output reg_id_t    index_id,
    output phys_addr_t physical_address
);

    logic [1:0] mod_field;
    logic [2:0] rm;
    logic       direct;
    logic       use_base;
    logic       use_index;
    logic       use_disp;
    word_t      offset;
    word_t      segment;

    assign mod_field = modrm[7:6];
    assign rm        = modrm[2:0];
    assign direct    = (mod_field == 2'b00) && (rm == RM_DIRECT);

    // BX for 000 001 111, BP for 010 011 110
    assign base_id  = (rm == 3'b010 || rm == 3'b011 || rm == 3'b110) ? REG_BP : REG_BX;
    // SI on even rm, DI on odd rm
    assign index_id = rm[0] ? REG_DI : REG_SI;

    // 100 and 101 are index only, 110 and 111 base only
    assign use_base  = (rm[2:1] != 2'b10) && !direct;
    assign use_index = (rm[2:1] != 2'b11);
    // mod 00 holds no displacement except in direct mode
    assign use_disp  = (mod_field != 2'b00) || direct;

    // 16-bit sum wraps within the segment
    assign offset = (use_base ? base_data : '0)
                  + (use_index ? index_data : '0)
                  + (use_disp ? disp : '0);

    // BP based addressing defaults to the stack segment
    assign segment = (use_base && base_id == REG_BP) ? ss : ds;

    assign physical_address = (phys_addr_t'(segment) << SEGMENT_SHIFT) + phys_addr_t'(offset);

endmodule

//--- rtl/mov_execute.sv
`timescale 1ns/1ps

module mov_execute
    import eu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         operands_valid,
    input  mov_kind_t    kind,
    input  logic         word_op,
    input  logic         rm_is_memory,
    input  reg_id_t      reg_field,
    input  reg_id_t      rm_field,
    input  word_t        imm,
    input  word_t        read_data,
    input  phys_addr_t   physical_address,
    input  word_t        data_in,
    input  logic         bus_command_done,
    output reg_id_t      read_id,
    output reg_id_t      write_id,
    output logic         write_word,
    output logic         write_enable,
    output word_t        write_data,
    output bus_command_t bus_command,
    output phys_addr_t   bus_address,
    output logic         bus_word,
    output word_t        data_out,
    output logic         instruction_done
);

    exec_state_t state;

    logic needs_bus;
    logic imm_source;
    logic to_register;
    logic start;

    // immediate to register has no modrm, so rm_is_memory is stale there
    assign needs_bus = rm_is_memory
                    && (kind == MOV_REG_FROM_RM || kind == MOV_RM_FROM_REG
                        || kind == MOV_RM_FROM_IMM);
    assign imm_source  = (kind == MOV_REG_FROM_IMM) || (kind == MOV_RM_FROM_IMM);
    assign to_register = (kind != MOV_NONE) && !needs_bus;
    assign start       = (state == EXEC_START) && operands_valid;

    // register source is reg for stores, rm for register to register loads
    assign read_id  = (kind == MOV_RM_FROM_REG) ? reg_field : rm_field;
    assign write_id = (kind == MOV_REG_FROM_RM || kind == MOV_REG_FROM_IMM) ? reg_field
                                                                              : rm_field;
    assign write_word = word_op;

    // bus data arrives only while a read is outstanding
    always_comb
    begin
        if (state == EXEC_BUS)
            write_data = data_in;
        else if (imm_source)
            write_data = imm;
        else
            write_data = read_data;
    end

    assign write_enable = (start && to_register)
                       || ((state == EXEC_BUS) && bus_command_done
                           && (bus_command == BUS_READ));

    // register moves and unknown opcodes finish in their first cycle
    assign instruction_done = (start && !needs_bus) || (state == EXEC_FINISH);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= EXEC_START;
            bus_command <= BUS_IDLE;
        end
        else
        begin
            case (state)
                EXEC_START:
                    if (start && needs_bus)
                    begin
                        bus_command <= (kind == MOV_REG_FROM_RM) ? BUS_READ : BUS_WRITE;
                        state       <= EXEC_BUS;
                    end
                EXEC_BUS:
                    // command held until the bus answers
                    if (bus_command_done)
                    begin
                        bus_command <= BUS_IDLE;
                        state       <= EXEC_FINISH;
                    end
                default:
                    state <= EXEC_START;
            endcase
        end
    end

    // address and store data captured once and held through the bus cycle
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            bus_address <= physical_address;
            bus_word    <= word_op;
            data_out    <= imm_source ? imm : read_data;
        end
    end

endmodule

//--- rtl/execution_unit.sv
`timescale 1ns/1ps

module execution_unit
    import eu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  byte_t        prefetch_data,
    input  logic         queue_empty,
    output logic         queue_pop,
    input  word_t        ds,
    input  word_t        ss,
    output bus_command_t bus_command,
    output phys_addr_t   bus_address,
    output logic         bus_word,
    output word_t        data_out,
    input  word_t        data_in,
    input  logic         bus_command_done,
    output logic         instruction_done
);

    // instruction fields
    byte_t opcode;
    byte_t modrm;
    word_t disp;
    word_t imm;
    logic  operands_valid;

    // decode results
    logic      need_modrm;
    logic      need_disp;
    logic      disp_word;
    logic      need_imm;
    logic      imm_word;
    logic      word_op;
    mov_kind_t kind;
    reg_id_t   reg_field;
    reg_id_t   rm_field;
    logic      rm_is_memory;

    // register file and address generator
    reg_id_t    read_id;
    reg_id_t    write_id;
    reg_id_t    base_id;
    reg_id_t    index_id;
    logic       write_word;
    logic       write_enable;
    word_t      write_data;
    word_t      read_data;
    word_t      base_data;
    word_t      index_data;
    phys_addr_t physical_address;

    mov_decode mov_decode_i
    (
        .opcode(opcode),
        .modrm(modrm),
        .need_modrm(need_modrm),
        .need_disp(need_disp),
        .disp_word(disp_word),
        .need_imm(need_imm),
        .imm_word(imm_word),
        .word_op(word_op),
        .kind(kind),
        .reg_field(reg_field),
        .rm_field(rm_field),
        .rm_is_memory(rm_is_memory)
    );

    instruction_fetch instruction_fetch_i
    (
        .clk(clk),
        .reset(reset),
        .prefetch_data(prefetch_data),
        .queue_empty(queue_empty),
        .need_modrm(need_modrm),
        .need_disp(need_disp),
        .disp_word(disp_word),
        .need_imm(need_imm),
        .imm_word(imm_word),
        .instruction_done(instruction_done),
        .queue_pop(queue_pop),
        .opcode(opcode),
        .modrm(modrm),
        .disp(disp),
        .imm(imm),
        .operands_valid(operands_valid)
    );

    // data port follows the move width, address ports are word wide
    register_file register_file_i
    (
        .clk(clk),
        .reset(reset),
        .read_id(read_id),
        .read_word(word_op),
        .addr_base_id(base_id),
        .addr_index_id(index_id),
        .write_id(write_id),
        .write_word(write_word),
        .write_enable(write_enable),
        .write_data(write_data),
        .read_data(read_data),
        .base_data(base_data),
        .index_data(index_data)
    );

    effective_address effective_address_i
    (
        .modrm(modrm),
        .disp(disp),
        .base_data(base_data),
        .index_data(index_data),
        .ds(ds),
        .ss(ss),
        .base_id(base_id),
        .index_id(index_id),
        .physical_address(physical_address)
    );

    mov_execute mov_execute_i
    (
        .clk(clk),
        .reset(reset),
        .operands_valid(operands_valid),
        .kind(kind),
        .word_op(word_op),
        .rm_is_memory(rm_is_memory),
        .reg_field(reg_field),
        .rm_field(rm_field),
        .imm(imm),
        .read_data(read_data),
        .physical_address(physical_address),
        .data_in(data_in),
        .bus_command_done(bus_command_done),
        .read_id(read_id),
        .write_id(write_id),
        .write_word(write_word),
        .write_enable(write_enable),
        .write_data(write_data),
        .bus_command(bus_command),
        .bus_address(bus_address),
        .bus_word(bus_word),
        .data_out(data_out),
        .instruction_done(instruction_done)
    );

endmodule

//--- bench/bus_checker.sv
`timescale 1ns/1ps

module bus_checker
    import eu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  bus_command_t bus_command,
    input  phys_addr_t   bus_address,
    input  logic         bus_word,
    input  word_t        data_out,
    input  logic         bus_command_done,
    input  logic         instruction_done,
    input  logic         run_complete,
    input  int           expected_instructions,
    output int           error_count,
    output int           transaction_count,
    output int           done_count,
    output logic         report_done
);

    // expected transactions in trace order
    bus_command_t expected_command_q [$];
    phys_addr_t   expected_address_q [$];
    logic         expected_word_q [$];
    word_t        expected_data_q [$];

    // command seen last cycle that was still waiting for its done
    logic         pending;
    bus_command_t held_command;
    phys_addr_t   held_address;
    logic         held_word;
    word_t        held_data;

    task automatic expect_transaction(input bus_command_t command, input phys_addr_t address,
                                      input logic word, input word_t data);
        expected_command_q.push_back(command);
        expected_address_q.push_back(address);
        expected_word_q.push_back(word);
        expected_data_q.push_back(data);
    endtask

    // reads carry no data to check, byte writes only their low half
    function automatic logic data_matches(input bus_command_t command, input logic word,
                                          input word_t actual, input word_t expected);
        if (command != BUS_WRITE)
            return 1'b1;
        if (word)
            return actual == expected;
        return actual[7:0] == expected[7:0];
    endfunction

    task automatic check_transaction();
        bus_command_t command;
        phys_addr_t   address;
        logic         word;
        word_t        data;
        if (expected_command_q.size() == 0)
        begin
            $display("extra bus %s at %05h after all expected transactions",
                     bus_command.name(), bus_address);
            error_count++;
        end
        else
        begin
            command = expected_command_q.pop_front();
            address = expected_address_q.pop_front();
            word    = expected_word_q.pop_front();
            data    = expected_data_q.pop_front();
            if (bus_command != command || bus_address != address || bus_word != word
                || !data_matches(command, word, data_out, data))
            begin
                // each triple is address/word/data
                $display("ERROR %0t: bus cycle %0d got %s %05h/%0b/%04h, expected %s %05h/%0b/%04h",
                         $time, transaction_count, bus_command.name(), bus_address, bus_word,
                         data_out, command.name(), address, word, data);
                error_count++;
            end
        end
        transaction_count++;
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            error_count       = 0;
            transaction_count = 0;
            done_count        = 0;
            report_done       = 1'b0;
            pending           = 1'b0;
        end
        else
        begin
            // address, width and data hold until the bus answers
            if (pending && (bus_command != held_command || bus_address != held_address
                            || bus_word != held_word || data_out != held_data))
            begin
                $display("ERROR %0t: bus command changed before bus_command_done", $time);
                error_count++;
            end
            if (bus_command != BUS_IDLE && bus_command_done)
                check_transaction();
            if (instruction_done)
                done_count++;

            pending      = (bus_command != BUS_IDLE) && !bus_command_done;
            held_command = bus_command;
            held_address = bus_address;
            held_word    = bus_word;
            held_data    = data_out;

            if (run_complete && !report_done)
            begin
                if (expected_command_q.size() != 0)
                begin
                    $display("%0d expected bus transactions never happened",
                             expected_command_q.size());
                    error_count++;
                end
                if (done_count != expected_instructions)
                begin
                    $display("instruction_done pulsed %0d times for %0d trace instructions",
                             done_count, expected_instructions);
                    error_count++;
                end
                report_done = 1'b1;
            end
        end
    end

endmodule

//--- bench/execution_unit_tb.sv
`timescale 1ns/1ps

module execution_unit_tb
    import eu_pkg::*;
();

    logic         clk;
    logic         reset;
    byte_t        prefetch_data;
    logic         queue_empty;
    logic         queue_pop;
    word_t        ds;
    word_t        ss;
    bus_command_t bus_command;
    phys_addr_t   bus_address;
    logic         bus_word;
    word_t        data_out;
    word_t        data_in;
    logic         bus_command_done;
    logic         instruction_done;

    // checker handshake and counts
    logic run_complete;
    logic report_done;
    int   error_count;
    int   transaction_count;
    int   done_count;

    // stimulus taken from the trace
    byte_t  byte_q [$];
    word_t  read_data_q [$];
    int     instruction_total;
    int     trace_errors;
    logic   trace_loaded;

    // input model state
    integer seed;
    int     wait_cycles;
    logic   waiting;
    logic   popped;
    logic   running;

    execution_unit execution_unit_i
    (
        .clk(clk),
        .reset(reset),
        .prefetch_data(prefetch_data),
        .queue_empty(queue_empty),
        .queue_pop(queue_pop),
        .ds(ds),
        .ss(ss),
        .bus_command(bus_command),
        .bus_address(bus_address),
        .bus_word(bus_word),
        .data_out(data_out),
        .data_in(data_in),
        .bus_command_done(bus_command_done),
        .instruction_done(instruction_done)
    );

    bus_checker bus_checker_i
    (
        .clk(clk),
        .reset(reset),
        .bus_command(bus_command),
        .bus_address(bus_address),
        .bus_word(bus_word),
        .data_out(data_out),
        .bus_command_done(bus_command_done),
        .instruction_done(instruction_done),
        .run_complete(run_complete),
        .expected_instructions(instruction_total),
        .error_count(error_count),
        .transaction_count(transaction_count),
        .done_count(done_count),
        .report_done(report_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // flags a trace record whose fields did not all parse
    task automatic report_bad_record(input logic [7:0] tag);
        $display("trace record %c has missing or unreadable fields", tag);
        trace_errors++;
    endtask

    // parses the trace into queue bytes, read data and expected transactions
    task automatic load_trace();
        int          fd;
        int          code;
        int          count;
        int          ch;
        logic [7:0]  tag;
        logic [31:0] address;
        logic [31:0] width;
        logic [31:0] value;
        fd = $fopen("bench/mov_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the trace file bench/mov_trace.txt");
            trace_errors++;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1)
        begin
            case (tag)
                "#":
                begin
                    // skip the rest of the line up to newline character 10
                    ch = 0;
                    while (ch != 10 && ch != -1)
                        ch = $fgetc(fd);
                end
                "S":
                begin
                    code = $fscanf(fd, "%h %h", ds, ss);
                    if (code != 2)
                        report_bad_record(tag);
                end
                "I":
                begin
                    code = $fscanf(fd, "%d", count);
                    if (code != 1)
                    begin
                        report_bad_record(tag);
                        count = 0;
                    end
                    for (int i = 0; i < count; i++)
                    begin
                        code = $fscanf(fd, "%h", value);
                        if (code != 1)
                            report_bad_record(tag);
                        byte_q.push_back(value[7:0]);
                    end
                    instruction_total++;
                end
                "R", "W":
                begin
                    code = $fscanf(fd, "%h %h %h", address, width, value);
                    if (code != 3)
                        report_bad_record(tag);
                    if (tag == "R")
                        read_data_q.push_back(value[15:0]);
                    bus_checker_i.expect_transaction((tag == "R") ? BUS_READ : BUS_WRITE,
                                                     address[19:0], width[0], value[15:0]);
                end
                default:
                begin
                    $display("trace holds an unknown record type %c", tag);
                    trace_errors++;
                end
            endcase
        end
        $fclose(fd);
    endtask

    // queue model and bus responder drive 1 ns after the edge
    initial
    begin
        prefetch_data    = 8'h00;
        queue_empty      = 1'b1;
        data_in          = 16'h0000;
        bus_command_done = 1'b0;
        seed        = 32'h9b07;
        waiting     = 1'b0;
        wait_cycles = 0;
        forever
        begin
            @(posedge clk);
            popped  = queue_pop && !queue_empty && !reset;
            running = !reset;
            #1;
            if (popped)
                void'(byte_q.pop_front());
            // the queue goes empty roughly one cycle in four
            queue_empty   = !running || (byte_q.size() == 0) || ({$random(seed)} % 4 == 0);
            prefetch_data = (byte_q.size() > 0) ? byte_q[0] : 8'h00;

            bus_command_done = 1'b0;
            data_in          = 16'h0000;
            if (running && bus_command != BUS_IDLE)
            begin
                if (!waiting)
                begin
                    wait_cycles = {$random(seed)} % 4;
                    waiting     = 1'b1;
                end
                if (wait_cycles == 0)
                begin
                    bus_command_done = 1'b1;
                    waiting          = 1'b0;
                    if (bus_command == BUS_READ && read_data_q.size() > 0)
                        data_in = read_data_q.pop_front();
                end
                else
                    wait_cycles--;
            end
        end
    end

    // watchdog sized from the number of trace instructions
    initial
    begin
        wait (trace_loaded);
        repeat (200 * instruction_total + 20) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles",
                 200 * instruction_total + 20);
        $display("test failed");
        $finish;
    end

    initial
    begin
        reset             = 1'b1;
        ds                = 16'h0000;
        ss                = 16'h0000;
        run_complete      = 1'b0;
        instruction_total = 0;
        trace_errors      = 0;
        trace_loaded      = 1'b0;
        load_trace();
        trace_loaded = 1'b1;

        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        wait (done_count >= instruction_total);
        // a few idle cycles so stray bus cycles still get seen
        repeat (8) @(posedge clk);
        #1 run_complete = 1'b1;
        wait (report_done);

        $display("errors: %0d, bus transactions: %0d, instructions done: %0d of %0d",
                 error_count + trace_errors, transaction_count, done_count, instruction_total);
        if (error_count + trace_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- bench/mov_trace.txt
# S ds ss | I count bytes | R addr width data (read, data returned) | W addr width data (expected write)
# all values hex except the I byte count, width 1 is a word and 0 a byte
S 1000 f800
I 3 b8 34 12   I 2 b4 56
I 4 89 06 00 01   W 10100 1 5634
I 4 88 26 02 01   W 10102 0 0056
I 4 8b 1e 00 02   R 10200 1 beef
I 4 89 1e 10 02   W 10210 1 beef
I 1 90
I 3 bb 00 10   I 3 be 20 00   I 3 bf 40 00   I 3 bd 00 90
I 2 8b 08         R 11020 1 0001
I 3 8b 49 04      R 11044 1 0002
I 4 8b 8a 00 01   R 01120 1 0003
I 3 8b 4b fe      R 0103e 1 0004
I 2 8b 0c         R 10020 1 0005
I 4 8b 8d f0 ff   R 10030 1 0006
I 3 8b 4e 80      R 00f80 1 0007
I 2 8b 0f         R 11000 1 0008
I 3 8a 57 05      R 11005 0 00a5
I 4 89 16 20 01   W 10120 1 00a5
I 2 89 d9
I 4 89 0e 30 01   W 10130 1 1000
I 3 c6 c1 99
I 4 89 0e 32 01   W 10132 1 1099
I 5 c7 47 10 cd ab   W 11010 1 abcd
I 5 c6 84 00 02 7e   W 10220 0 007e
I 1 f4

//--- all.f
rtl/eu_pkg.sv
rtl/mov_decode.sv
rtl/instruction_fetch.sv
rtl/register_file.sv
rtl/effective_address.sv
rtl/mov_execute.sv
rtl/execution_unit.sv
bench/bus_checker.sv
bench/execution_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = execution_unit_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

BINARY  = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -q "test passed"

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
